// ==== rx_cfg.svh ====
`ifndef RX_CFG_SVH
`define RX_CFG_SVH

// beat and local bus widths
`define RX_DATA_W 64
`define RX_ADDR_W 32

// packet length field, counted in payload beats
`define RX_LEN_W 4
`define RX_MAX_LEN 8

// eight completion tags
`define RX_TAG_W 3

// one region of RX_MAX_LEN words per tag
`define RX_CPL_DEPTH (`RX_MAX_LEN * 8)

// pending read requests waiting for the transmit side
`define RX_PNDG_DEPTH 16

// single address window
// low RX_BAR_W bits of the packet address are kept and ORed onto the base
`define RX_BAR_W 20
`define RX_AVL_BASE 32'h8000_0000

`endif

// ==== rx_pkg.sv ====
`include "rx_cfg.svh"

package rx_pkg;

   // header opcodes, anything else decodes to OP_OTHER
   typedef enum logic [2:0] {
      OP_MRD   = 3'b000,
      OP_MWR   = 3'b010,
      OP_CPLD  = 3'b101,
      OP_OTHER = 3'b111
   } rx_op_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WR_DATA,
      ST_CPL_DATA,
      ST_RD_PUSH
   } rx_state_e;

   // header beat as it sits in the data field
   typedef struct packed {
      logic [`RX_DATA_W-`RX_ADDR_W-`RX_TAG_W-`RX_LEN_W-4:0] rsvd;
      logic [2:0]            op;
      logic [`RX_LEN_W-1:0]  len;
      logic [`RX_TAG_W-1:0]  tag;
      logic [`RX_ADDR_W-1:0] addr;
   } rx_hdr_t;

   typedef struct packed {
      logic [`RX_DATA_W-1:0] data;
      logic                  sop;
      logic                  eop;
      logic                  valid;
   } rx_beat_t;

   typedef struct packed {
      logic [`RX_ADDR_W-1:0]   addr;
      logic [`RX_DATA_W-1:0]   data;
      logic [`RX_DATA_W/8-1:0] be;
   } avl_wr_t;

   typedef struct packed {
      logic [`RX_TAG_W-1:0]  tag;
      logic [`RX_LEN_W-1:0]  len;
      logic [`RX_ADDR_W-1:0] addr;
   } pndg_rd_t;

   typedef struct packed {
      logic [`RX_TAG_W-1:0] tag;
      logic [`RX_LEN_W-1:0] len;
   } cpl_desc_t;

endpackage

// ==== rx_tlp_sm.sv ====
`include "rx_cfg.svh"

module rx_tlp_sm (
   input  logic                              Clk_i,
   input  logic                              Rstn_i,
   input  rx_pkg::rx_beat_t                  beat_i,
   output logic                              ready_o,
   input  logic                              wr_busy_i,
   output logic                              wr_stb_o,
   output rx_pkg::avl_wr_t                   wr_o,
   output logic                              cnt_load_o,
   output logic                              cnt_step_o,
   input  logic [`RX_LEN_W-1:0]              cnt_idx_i,
   input  logic                              cnt_last_i,
   input  logic                              pndg_full_i,
   output logic                              pndg_push_o,
   output rx_pkg::pndg_rd_t                  pndg_o,
   output logic                              ram_we_o,
   output logic [$clog2(`RX_CPL_DEPTH)-1:0]  ram_addr_o,
   output logic [`RX_DATA_W-1:0]             ram_dat_o,
   output logic                              desc_stb_o,
   output rx_pkg::cpl_desc_t                 desc_o
);
   import rx_pkg::*;

   localparam int CPL_AW = $clog2(`RX_CPL_DEPTH);

   rx_state_e             state_q;
   rx_state_e             state_d;
   logic                  drop_q;
   rx_hdr_t               hdr;
   rx_op_e                op;
   logic                  take;
   logic                  hdr_take;
   logic                  data_take;
   logic [`RX_ADDR_W-1:0] win_addr;
   logic [`RX_ADDR_W-1:0] wr_base_q;
   pndg_rd_t              pndg_q;
   cpl_desc_t             cpl_q;

   assign hdr = rx_hdr_t'(beat_i.data);

   always_comb
   begin
      case (hdr.op)
         OP_MWR, OP_MRD, OP_CPLD: op = rx_op_e'(hdr.op);
         default:                 op = OP_OTHER;
      endcase
   end

   // keep the window bits and place them above the local base
   assign win_addr = `RX_AVL_BASE |
                     {{(`RX_ADDR_W-`RX_BAR_W){1'b0}}, hdr.addr[`RX_BAR_W-1:0]};

   // a full FIFO only blocks new headers, a stalled write blocks everything
   assign ready_o = !wr_busy_i &&
                    ((state_q == ST_WR_DATA) || (state_q == ST_CPL_DATA) ||
                     ((state_q == ST_IDLE) && !pndg_full_i));

   assign take      = beat_i.valid && ready_o;
   assign hdr_take  = take && (state_q == ST_IDLE) && !drop_q && beat_i.sop;
   assign data_take = take && ((state_q == ST_WR_DATA) || (state_q == ST_CPL_DATA));

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:
         begin
            if (hdr_take)
            begin
               case (op)
                  OP_MWR:  state_d = ST_WR_DATA;
                  OP_CPLD: state_d = ST_CPL_DATA;
                  OP_MRD:  state_d = ST_RD_PUSH;
                  default: state_d = ST_IDLE;
               endcase
            end
         end
         ST_WR_DATA, ST_CPL_DATA:
         begin
            if (data_take && cnt_last_i)
               state_d = ST_IDLE;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         state_q <= ST_IDLE;
         drop_q  <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         // unknown multi-beat packets are swallowed up to their eop
         if (hdr_take && (op == OP_OTHER) && !beat_i.eop)
            drop_q <= 1'b1;
         else if (take && (state_q == ST_IDLE) && drop_q && beat_i.eop)
            drop_q <= 1'b0;
      end
   end

   always_ff @(posedge Clk_i)
   begin
      if (hdr_take)
      begin
         wr_base_q   <= win_addr;
         pndg_q.tag  <= hdr.tag;
         pndg_q.len  <= hdr.len;
         pndg_q.addr <= win_addr;
         cpl_q.tag   <= hdr.tag;
         cpl_q.len   <= hdr.len;
      end
   end

   assign cnt_load_o = hdr_take && ((op == OP_MWR) || (op == OP_CPLD));
   assign cnt_step_o = data_take;

   // write payload goes straight to the master, one local write per beat
   assign wr_stb_o     = data_take && (state_q == ST_WR_DATA);
   assign wr_o.addr    = wr_base_q + `RX_ADDR_W'(cnt_idx_i) * (`RX_DATA_W / 8);
   assign wr_o.data    = beat_i.data;
   assign wr_o.be      = '1;

   // read header was latched on take, pushed here one cycle later
   assign pndg_push_o = (state_q == ST_RD_PUSH);
   assign pndg_o      = pndg_q;

   // completion beats fill the tag region from offset 0
   assign ram_we_o   = data_take && (state_q == ST_CPL_DATA);
   assign ram_addr_o = CPL_AW'(cpl_q.tag) * CPL_AW'(`RX_MAX_LEN) + CPL_AW'(cnt_idx_i);
   assign ram_dat_o  = beat_i.data;
   assign desc_stb_o = ram_we_o && cnt_last_i;
   assign desc_o     = cpl_q;

   // packet length in the header must agree with where the source puts eop
   a_eop_on_last: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      data_take |-> (beat_i.eop == cnt_last_i));

endmodule

// ==== rx_beat_counter.sv ====
`include "rx_cfg.svh"

module rx_beat_counter (
   input  logic                 Clk_i,
   input  logic                 Rstn_i,
   input  logic                 load_i,
   input  logic [`RX_LEN_W-1:0] len_i,
   input  logic                 step_i,
   output logic [`RX_LEN_W-1:0] idx_o,
   output logic                 last_o
);

   logic [`RX_LEN_W-1:0] len_q;
   logic                 armed_q;

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         idx_o   <= '0;
         len_q   <= '0;
         armed_q <= 1'b0;
      end
      else if (load_i)
      begin
         idx_o   <= '0;
         len_q   <= len_i;
         armed_q <= 1'b1;
      end
      else if (step_i)
      begin
         idx_o <= idx_o + 1'b1;
         // disarm once the final beat has gone by
         if (last_o)
            armed_q <= 1'b0;
      end
   end

   assign last_o = armed_q && (idx_o == len_q - 1'b1);

   // after the final beat only a new load may rearm the count
   a_no_step_past_last: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      (step_i && !load_i) |-> armed_q);

endmodule

// ==== rx_avl_wr_master.sv ====
`include "rx_cfg.svh"

module rx_avl_wr_master (
   input  logic             Clk_i,
   input  logic             Rstn_i,
   input  logic             stb_i,
   input  rx_pkg::avl_wr_t  wr_i,
   output logic             busy_o,
   output logic             avl_write_o,
   output rx_pkg::avl_wr_t  avl_o,
   input  logic             avl_wait_i
);
   import rx_pkg::*;

   // busy only while the bus holds the write off
   // a new beat can load in the cycle the current write completes
   assign busy_o = avl_write_o && avl_wait_i;

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
         avl_write_o <= 1'b0;
      else if (!busy_o)
         avl_write_o <= stb_i;
   end

   always_ff @(posedge Clk_i)
   begin
      if (!busy_o && stb_i)
         avl_o <= wr_i;
   end

endmodule

// ==== rx_pndg_rd_fifo.sv ====
`include "rx_cfg.svh"

module rx_pndg_rd_fifo (
   input  logic              Clk_i,
   input  logic              Rstn_i,
   input  logic              push_i,
   input  rx_pkg::pndg_rd_t  din_i,
   output logic              full_o,
   input  logic              pop_i,
   output rx_pkg::pndg_rd_t  head_o,
   output logic              empty_o
);
   import rx_pkg::*;

   localparam int AW = $clog2(`RX_PNDG_DEPTH);

   pndg_rd_t      mem [`RX_PNDG_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push_i)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge Clk_i)
   begin
      if (push_i)
         mem[wr_ptr] <= din_i;
   end

   // show-ahead, the head entry is visible before it is popped
   assign head_o  = mem[rd_ptr];
   assign full_o  = (count == (AW+1)'(`RX_PNDG_DEPTH));
   assign empty_o = (count == '0);

   a_no_push_full: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      push_i |-> !full_o);

   a_no_pop_empty: assert property (@(posedge Clk_i) disable iff (!Rstn_i)
      pop_i |-> !empty_o);

endmodule

// ==== rx_cpl_buffer.sv ====
`include "rx_cfg.svh"

module rx_cpl_buffer (
   input  logic                              Clk_i,
   input  logic                              Rstn_i,
   input  logic                              we_i,
   input  logic [$clog2(`RX_CPL_DEPTH)-1:0]  waddr_i,
   input  logic [`RX_DATA_W-1:0]             wdat_i,
   input  logic                              desc_stb_i,
   input  rx_pkg::cpl_desc_t                 desc_i,
   output logic [`RX_DATA_W-1:0]             rd_data_o,
   output logic                              rd_valid_o,
   output logic                              tag_release_o,
   output logic [`RX_TAG_W-1:0]              release_tag_o
);
   import rx_pkg::*;

   localparam int AW = $clog2(`RX_CPL_DEPTH);
   localparam int QD = 2 ** `RX_TAG_W;

   logic [`RX_DATA_W-1:0] ram [`RX_CPL_DEPTH];
   cpl_desc_t             dq [QD];
   logic [`RX_TAG_W-1:0]  dq_wr;
   logic [`RX_TAG_W-1:0]  dq_rd;
   logic [`RX_TAG_W:0]    dq_cnt;
   logic                  dq_pop;
   logic                  seq_act;
   cpl_desc_t             seq_desc;
   logic [`RX_LEN_W-1:0]  seq_idx;
   logic                  seq_last;
   logic [AW-1:0]         raddr;

   always_ff @(posedge Clk_i)
   begin
      if (we_i)
         ram[waddr_i] <= wdat_i;
      if (desc_stb_i)
         dq[dq_wr] <= desc_i;
   end

   // descriptor queue, one slot per tag
   assign dq_pop = !seq_act && (dq_cnt != '0);

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         dq_wr  <= '0;
         dq_rd  <= '0;
         dq_cnt <= '0;
      end
      else
      begin
         if (desc_stb_i)
            dq_wr <= dq_wr + 1'b1;
         if (dq_pop)
            dq_rd <= dq_rd + 1'b1;
         dq_cnt <= dq_cnt + (desc_stb_i ? 1'b1 : 1'b0) - (dq_pop ? 1'b1 : 1'b0);
      end
   end

   // sequencer walks the tag region in order
   assign seq_last = (seq_idx == seq_desc.len - 1'b1);
   assign raddr    = AW'(seq_desc.tag) * AW'(`RX_MAX_LEN) + AW'(seq_idx);

   always_ff @(posedge Clk_i or negedge Rstn_i)
   begin
      if (!Rstn_i)
      begin
         seq_act       <= 1'b0;
         seq_idx       <= '0;
         rd_valid_o    <= 1'b0;
         tag_release_o <= 1'b0;
      end
      else
      begin
         rd_valid_o    <= seq_act;
         tag_release_o <= seq_act && seq_last;
         if (dq_pop)
         begin
            seq_act <= 1'b1;
            seq_idx <= '0;
         end
         else if (seq_act)
         begin
            seq_idx <= seq_idx + 1'b1;
            if (seq_last)
               seq_act <= 1'b0;
         end
      end
   end

   always_ff @(posedge Clk_i)
   begin
      if (dq_pop)
         seq_desc <= dq[dq_rd];
      // registered read, data lines up with valid
      rd_data_o     <= ram[raddr];
      release_tag_o <= seq_desc.tag;
   end

endmodule

// ==== rx_bridge_top.sv ====
`include "rx_cfg.svh"

module rx_bridge_top (
   input  logic                  Clk_i,
   input  logic                  Rstn_i,
   input  rx_pkg::rx_beat_t      rx_beat_i,
   output logic                  rx_ready_o,
   output logic                  avl_write_o,
   output rx_pkg::avl_wr_t       avl_wr_o,
   input  logic                  avl_wait_i,
   output rx_pkg::pndg_rd_t      pndg_rd_o,
   output logic                  pndg_empty_o,
   input  logic                  pndg_pop_i,
   output logic [`RX_DATA_W-1:0] rd_data_o,
   output logic                  rd_valid_o,
   output logic                  tag_release_o,
   output logic [`RX_TAG_W-1:0]  release_tag_o
);
   import rx_pkg::*;

   rx_hdr_t                          rx_hdr;
   logic                             wr_busy;
   logic                             wr_stb;
   avl_wr_t                          wr;
   logic                             cnt_load;
   logic                             cnt_step;
   logic [`RX_LEN_W-1:0]             cnt_idx;
   logic                             cnt_last;
   logic                             pndg_full;
   logic                             pndg_push;
   pndg_rd_t                         pndg;
   logic                             ram_we;
   logic [$clog2(`RX_CPL_DEPTH)-1:0] ram_addr;
   logic [`RX_DATA_W-1:0]            ram_dat;
   logic                             desc_stb;
   cpl_desc_t                        desc;

   // header view of the incoming beat for the counter length
   assign rx_hdr = rx_hdr_t'(rx_beat_i.data);

   rx_tlp_sm rx_tlp_sm_i (
      .Clk_i       (Clk_i),
      .Rstn_i      (Rstn_i),
      .beat_i      (rx_beat_i),
      .ready_o     (rx_ready_o),
      .wr_busy_i   (wr_busy),
      .wr_stb_o    (wr_stb),
      .wr_o        (wr),
      .cnt_load_o  (cnt_load),
      .cnt_step_o  (cnt_step),
      .cnt_idx_i   (cnt_idx),
      .cnt_last_i  (cnt_last),
      .pndg_full_i (pndg_full),
      .pndg_push_o (pndg_push),
      .pndg_o      (pndg),
      .ram_we_o    (ram_we),
      .ram_addr_o  (ram_addr),
      .ram_dat_o   (ram_dat),
      .desc_stb_o  (desc_stb),
      .desc_o      (desc)
   );

   rx_beat_counter rx_beat_counter_i (
      .Clk_i  (Clk_i),
      .Rstn_i (Rstn_i),
      .load_i (cnt_load),
      .len_i  (rx_hdr.len),
      .step_i (cnt_step),
      .idx_o  (cnt_idx),
      .last_o (cnt_last)
   );

   rx_avl_wr_master rx_avl_wr_master_i (
      .Clk_i       (Clk_i),
      .Rstn_i      (Rstn_i),
      .stb_i       (wr_stb),
      .wr_i        (wr),
      .busy_o      (wr_busy),
      .avl_write_o (avl_write_o),
      .avl_o       (avl_wr_o),
      .avl_wait_i  (avl_wait_i)
   );

   rx_pndg_rd_fifo rx_pndg_rd_fifo_i (
      .Clk_i   (Clk_i),
      .Rstn_i  (Rstn_i),
      .push_i  (pndg_push),
      .din_i   (pndg),
      .full_o  (pndg_full),
      .pop_i   (pndg_pop_i),
      .head_o  (pndg_rd_o),
      .empty_o (pndg_empty_o)
   );

   rx_cpl_buffer rx_cpl_buffer_i (
      .Clk_i         (Clk_i),
      .Rstn_i        (Rstn_i),
      .we_i          (ram_we),
      .waddr_i       (ram_addr),
      .wdat_i        (ram_dat),
      .desc_stb_i    (desc_stb),
      .desc_i        (desc),
      .rd_data_o     (rd_data_o),
      .rd_valid_o    (rd_valid_o),
      .tag_release_o (tag_release_o),
      .release_tag_o (release_tag_o)
   );

endmodule

// ==== tb_rx_bridge.sv ====
`include "rx_cfg.svh"

module tb_rx_bridge;
   import rx_pkg::*;

   // one stimulus row is one packet
   typedef struct packed {
      logic [2:0]            test;
      rx_op_e                op;
      logic [`RX_LEN_W-1:0]  len;
      logic [`RX_TAG_W-1:0]  tag;
      logic [`RX_ADDR_W-1:0] addr;
      logic [31:0]           seed;
   } pkt_row_t;

   // one beat of read data as seen on the completion side
   typedef struct packed {
      logic [`RX_DATA_W-1:0] data;
      logic                  last;
      logic [`RX_TAG_W-1:0]  tag;
   } cpl_beat_t;

   localparam int N_ROWS     = 9;
   localparam int N_FULL     = `RX_PNDG_DEPTH + 1;
   localparam int WATCHDOG_T = (N_ROWS + N_FULL) * (`RX_MAX_LEN + 20) * 4;

   localparam pkt_row_t ROWS [N_ROWS] = '{
      '{3'd1, OP_MWR,   4'd3, 3'd0, 32'h1234_5008, 32'h0000_1111},
      '{3'd1, OP_MWR,   4'd8, 3'd0, 32'hFFF0_0100, 32'h0000_2222},
      '{3'd1, OP_MWR,   4'd1, 3'd0, 32'h0007_FFF8, 32'h0000_3333},
      '{3'd2, OP_MRD,   4'd4, 3'd2, 32'h0002_3440, 32'h0000_0000},
      '{3'd2, OP_MRD,   4'd1, 3'd5, 32'hABCF_FFF8, 32'h0000_0000},
      '{3'd3, OP_CPLD,  4'd4, 3'd1, 32'h0000_0000, 32'h0000_4444},
      '{3'd3, OP_CPLD,  4'd2, 3'd3, 32'h0000_0000, 32'h0000_5555},
      '{3'd3, OP_CPLD,  4'd8, 3'd6, 32'h0000_0000, 32'h0000_6666},
      '{3'd4, OP_OTHER, 4'd2, 3'd0, 32'h0000_0040, 32'h0000_7777}
   };

   string test_name [6] = '{"reset", "writes", "reads", "completions",
                            "unknown opcode", "full FIFO"};

   logic                  Clk_i;
   logic                  Rstn_i;
   rx_beat_t              rx_beat;
   logic                  rx_ready;
   logic                  avl_write;
   avl_wr_t               avl_wr;
   logic                  avl_wait;
   pndg_rd_t              pndg_rd;
   logic                  pndg_empty;
   logic                  pndg_pop;
   logic [`RX_DATA_W-1:0] rd_data;
   logic                  rd_valid;
   logic                  tag_release;
   logic [`RX_TAG_W-1:0]  release_tag;
   logic                  pop_en;

   avl_wr_t   exp_wr [$];
   pndg_rd_t  exp_rd [$];
   cpl_beat_t exp_cpl [$];
   int        errors;
   int        checks;
   int        err_mark;

   rx_bridge_top rx_bridge_top_i (
      .Clk_i         (Clk_i),
      .Rstn_i        (Rstn_i),
      .rx_beat_i     (rx_beat),
      .rx_ready_o    (rx_ready),
      .avl_write_o   (avl_write),
      .avl_wr_o      (avl_wr),
      .avl_wait_i    (avl_wait),
      .pndg_rd_o     (pndg_rd),
      .pndg_empty_o  (pndg_empty),
      .pndg_pop_i    (pndg_pop),
      .rd_data_o     (rd_data),
      .rd_valid_o    (rd_valid),
      .tag_release_o (tag_release),
      .release_tag_o (release_tag)
   );

   initial
   begin
      Clk_i = 1'b0;
      forever #2 Clk_i = ~Clk_i;
   end

   function automatic logic [`RX_DATA_W-1:0] beat_data(logic [31:0] seed, int i);
      return {seed, seed ^ (32'(i + 1) * 32'h9E37_79B9)};
   endfunction

   // window bits of the packet address on top of the local base
   function automatic logic [`RX_ADDR_W-1:0] local_addr(logic [`RX_ADDR_W-1:0] addr);
      return `RX_AVL_BASE | (addr & ((32'd1 << `RX_BAR_W) - 32'd1));
   endfunction

   function automatic pkt_row_t full_row(int i);
      return '{3'd5, OP_MRD, 4'(i % 8 + 1), 3'(i), 32'h0004_0000 + 32'(i * 64), 32'h0};
   endfunction

   task automatic note_mismatch(string msg);
      $display("[FAIL] t=%0t %s", $time, msg);
      errors++;
   endtask

   task automatic raise_error(string msg);
      $display("error at t=%0t: %s", $time, msg);
      errors++;
   endtask

   task automatic check_avl_wr(avl_wr_t got, avl_wr_t exp);
      checks++;
      if (got !== exp)
         note_mismatch($sformatf("local write %h/%h/%h, expected %h/%h/%h",
                                 got.addr, got.data, got.be, exp.addr, exp.data, exp.be));
   endtask

   task automatic check_pndg_rd(pndg_rd_t got, pndg_rd_t exp);
      checks++;
      if (got !== exp)
         note_mismatch($sformatf("pending read tag %0d len %0d addr %h, expected %0d %0d %h",
                                 got.tag, got.len, got.addr, exp.tag, exp.len, exp.addr));
   endtask

   task automatic check_cpl(cpl_beat_t got, cpl_beat_t exp);
      checks++;
      if (got.data !== exp.data || got.last !== exp.last || (exp.last && got.tag !== exp.tag))
         note_mismatch($sformatf("read data %h last %b tag %0d, expected %h %b %0d",
                                 got.data, got.last, got.tag, exp.data, exp.last, exp.tag));
   endtask

   // random wait-request and pops that only come while the FIFO holds an entry
   initial
   begin
      void'($urandom(52084));
      forever
      begin
         @(negedge Clk_i);
         avl_wait <= ($urandom % 4) == 0;
         pndg_pop <= pop_en && !pndg_empty;
      end
   end

   always @(posedge Clk_i)
   begin
      if (Rstn_i)
      begin
         if (avl_write && !avl_wait)
         begin
            if (exp_wr.size() == 0)
               raise_error("local write appeared with none expected");
            else
               check_avl_wr(avl_wr, exp_wr.pop_front());
         end
         if (pndg_pop)
         begin
            if (exp_rd.size() == 0)
               raise_error("pending read popped with none expected");
            else
               check_pndg_rd(pndg_rd, exp_rd.pop_front());
         end
         if (tag_release && !rd_valid)
            raise_error("tag release pulsed without read data");
         if (rd_valid)
         begin
            if (exp_cpl.size() == 0)
               raise_error("read data appeared with none expected");
            else
               check_cpl({rd_data, tag_release, release_tag}, exp_cpl.pop_front());
         end
      end
   end

   task automatic queue_expected(pkt_row_t row);
      avl_wr_t   w;
      pndg_rd_t  r;
      cpl_beat_t c;
      for (int i = 0; i < row.len; i++)
      begin
         w.addr = local_addr(row.addr) + 32'(8 * i);
         w.data = beat_data(row.seed, i);
         w.be   = '1;
         c.data = beat_data(row.seed, i);
         c.last = (i == row.len - 1);
         c.tag  = row.tag;
         if (row.op == OP_MWR)
            exp_wr.push_back(w);
         if (row.op == OP_CPLD)
            exp_cpl.push_back(c);
      end
      r.tag  = row.tag;
      r.len  = row.len;
      r.addr = local_addr(row.addr);
      if (row.op == OP_MRD)
         exp_rd.push_back(r);
   endtask

   // called on a falling edge and returns on the falling edge after the beat is taken
   task automatic drive_beat(logic [`RX_DATA_W-1:0] data, logic sop, logic eop);
      rx_beat = '{data: data, sop: sop, eop: eop, valid: 1'b1};
      do
         @(posedge Clk_i);
      while (!rx_ready);
      @(negedge Clk_i);
      rx_beat.valid = 1'b0;
   endtask

   task automatic send_packet(pkt_row_t row);
      rx_hdr_t hdr;
      hdr      = '0;
      hdr.op   = row.op;
      hdr.len  = row.len;
      hdr.tag  = row.tag;
      hdr.addr = row.addr;
      drive_beat(hdr, 1'b1, row.op == OP_MRD);
      if (row.op != OP_MRD)
         for (int i = 0; i < row.len; i++)
            drive_beat(beat_data(row.seed, i), 1'b0, i == row.len - 1);
   endtask

   task automatic finish_test(int t);
      while (exp_wr.size() + exp_rd.size() + exp_cpl.size() != 0)
         @(negedge Clk_i);
      // quiet time so that any stray output still reaches a monitor
      repeat (6) @(negedge Clk_i);
      if (!pndg_empty)
         raise_error("pending-read FIFO not empty at the end of the test");
      $display("test %-15s done, %0d errors", test_name[t], errors - err_mark);
      err_mark = errors;
   endtask

   initial
   begin
      int cur;
      Rstn_i   = 1'b0;
      rx_beat  = '0;
      avl_wait = 1'b0;
      pndg_pop = 1'b0;
      pop_en   = 1'b1;
      errors   = 0;
      checks   = 0;
      err_mark = 0;
      repeat (8) @(negedge Clk_i);
      checks++;
      if (!rx_ready || !pndg_empty || avl_write || rd_valid || tag_release)
         note_mismatch("outputs not idle in reset");
      Rstn_i = 1'b1;
      finish_test(0);

      cur = ROWS[0].test;
      for (int r = 0; r < N_ROWS; r++)
      begin
         if (ROWS[r].test != cur)
         begin
            finish_test(cur);
            cur = ROWS[r].test;
         end
         queue_expected(ROWS[r]);
         send_packet(ROWS[r]);
      end
      finish_test(cur);

      // fill the pending-read FIFO so that the last read must wait for a pop
      @(posedge Clk_i);
      pop_en = 1'b0;
      @(negedge Clk_i);
      for (int i = 0; i < N_FULL; i++)
         queue_expected(full_row(i));
      for (int i = 0; i < N_FULL - 1; i++)
         send_packet(full_row(i));
      fork
         send_packet(full_row(N_FULL - 1));
         begin
            repeat (6)
            begin
               @(posedge Clk_i);
               if (rx_ready)
                  raise_error("read header accepted while the pending-read FIFO was full");
            end
            pop_en = 1'b1;
         end
      join
      finish_test(5);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_T);
      $display("error: watchdog expired before all tests finished");
      $display("Something failed");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+.
rx_pkg.sv
rx_tlp_sm.sv
rx_beat_counter.sv
rx_avl_wr_master.sv
rx_pndg_rd_fifo.sv
rx_cpl_buffer.sv
rx_bridge_top.sv
tb_rx_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_rx_bridge
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Everything OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
